// File: flist.f
logic/fixed_pkg.sv
logic/skid_buffer.sv
logic/fixed_adder_tree_layer.sv
logic/fixed_adder_tree.sv
logic/fixed_vector_mult.sv
logic/fixed_dot_product.sv
tb/tb_fixed_dot_product.sv

// File: logic/fixed_adder_tree.sv
`timescale 1ns/1ns
`default_nettype none

module fixed_adder_tree #(
  parameter int IN_SIZE   = 8,
  parameter int IN_WIDTH  = 16,
  parameter int OUT_WIDTH = IN_WIDTH + fixed_pkg::tree_levels(IN_SIZE)
) (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic [IN_WIDTH-1:0]  data_in [IN_SIZE],
  input  wire logic                 data_in_valid,
  output logic                      data_in_ready,
  output logic      [OUT_WIDTH-1:0] data_out,
  output logic                      data_out_valid,
  input  wire logic                 data_out_ready
);

  import fixed_pkg::*;

  // One register stage per level
  localparam int LEVELS = tree_levels(IN_SIZE);

  // Data and handshake seen at the input of each level
  // Index 0 is the tree input, index LEVELS the tree output
  for (genvar i = 0; i <= LEVELS; i++) begin : g_lvl
    localparam int SIZE = level_size(IN_SIZE, i);

    // Width grows by one bit per level
    logic [IN_WIDTH+i-1:0] data [SIZE];
    logic                  valid;
    logic                  ready;
  end

  for (genvar i = 0; i < LEVELS; i++) begin : g_stage
    localparam int SIZE      = level_size(IN_SIZE, i);
    localparam int NEXT_SIZE = level_size(IN_SIZE, i + 1);
    localparam int SUM_WIDTH = IN_WIDTH + i + 1;

    // Pairwise sums of this level
    logic [SUM_WIDTH-1:0]           sum [NEXT_SIZE];

    // All sums packed into one word for the register slice
    logic [NEXT_SIZE*SUM_WIDTH-1:0] flat_sum;
    logic [NEXT_SIZE*SUM_WIDTH-1:0] flat_data;

    fixed_adder_tree_layer #(
      .IN_SIZE  (SIZE),
      .IN_WIDTH (IN_WIDTH + i)
    ) i_layer (
      .data_in  (g_lvl[i].data),
      .data_out (sum)
    );

    // Array to word
    for (genvar j = 0; j < NEXT_SIZE; j++) begin : g_pack
      assign flat_sum[j*SUM_WIDTH +: SUM_WIDTH] = sum[j];
    end

    // Whole level advances as one item
    skid_buffer #(
      .DATA_WIDTH (NEXT_SIZE * SUM_WIDTH)
    ) i_skid_buffer (
      .clk            (clk),
      .arst_n         (arst_n),
      .data_in        (flat_sum),
      .data_in_valid  (g_lvl[i].valid),
      .data_in_ready  (g_lvl[i].ready),
      .data_out       (flat_data),
      .data_out_valid (g_lvl[i+1].valid),
      .data_out_ready (g_lvl[i+1].ready)
    );

    // Word back to array for the next level
    for (genvar j = 0; j < NEXT_SIZE; j++) begin : g_unpack
      assign g_lvl[i+1].data[j] = flat_data[j*SUM_WIDTH +: SUM_WIDTH];
    end
  end

  // Tree input side
  assign g_lvl[0].data  = data_in;
  assign g_lvl[0].valid = data_in_valid;
  assign data_in_ready  = g_lvl[0].ready;

  // Tree output side
  // With a single element there are no levels, so input goes straight out
  assign data_out              = g_lvl[LEVELS].data[0];
  assign data_out_valid        = g_lvl[LEVELS].valid;
  assign g_lvl[LEVELS].ready   = data_out_ready;

endmodule

`default_nettype wire

// File: logic/fixed_adder_tree_layer.sv
`timescale 1ns/1ns
`default_nettype none

module fixed_adder_tree_layer #(
  parameter int IN_SIZE  = 2,
  parameter int IN_WIDTH = 16
) (
  input  wire logic [IN_WIDTH-1:0] data_in  [IN_SIZE],
  output logic      [IN_WIDTH:0]   data_out [fixed_pkg::level_size(IN_SIZE, 1)]
);

  import fixed_pkg::*;

  // Number of sums produced by this layer
  localparam int OUT_SIZE = level_size(IN_SIZE, 1);

  // Number of full pairs
  localparam int PAIRS = IN_SIZE / 2;

  // One adder per neighbouring pair
  // Operands are zero-extended so the carry is kept
  for (genvar k = 0; k < PAIRS; k++) begin : g_pair
    assign data_out[k] = {1'b0, data_in[2*k]} + {1'b0, data_in[2*k+1]};
  end

  // Odd count leaves the last element without a partner
  // it moves up one level unchanged, only widened
  if ((IN_SIZE % 2) != 0) begin : g_odd
    assign data_out[OUT_SIZE-1] = {1'b0, data_in[IN_SIZE-1]};
  end

endmodule

`default_nettype wire

// File: logic/fixed_dot_product.sv
`timescale 1ns/1ns
`default_nettype none

module fixed_dot_product #(
  parameter int IN_SIZE    = fixed_pkg::DEFAULT_IN_SIZE,
  parameter int DATA_WIDTH = fixed_pkg::DEFAULT_DATA_WIDTH
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic [DATA_WIDTH-1:0] a_in [IN_SIZE],
  input  wire logic [DATA_WIDTH-1:0] b_in [IN_SIZE],
  input  wire logic                  in_valid,
  output logic                       in_ready,
  output logic [fixed_pkg::product_width(DATA_WIDTH)+fixed_pkg::tree_levels(IN_SIZE)-1:0]
                                     sum_out,
  output logic                       out_valid,
  input  wire logic                  out_ready
);

  import fixed_pkg::*;

  // Product width entering the tree
  localparam int PROD_WIDTH = product_width(DATA_WIDTH);

  // One extra bit per tree level
  localparam int SUM_WIDTH  = PROD_WIDTH + tree_levels(IN_SIZE);

  // Multiplier to tree
  logic [PROD_WIDTH-1:0] prod [IN_SIZE];
  logic                  prod_valid;
  logic                  prod_ready;

  // Stage 1, elementwise products
  fixed_vector_mult #(
    .IN_SIZE    (IN_SIZE),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_fixed_vector_mult (
    .clk        (clk),
    .arst_n     (arst_n),
    .a_in       (a_in),
    .b_in       (b_in),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .prod_out   (prod),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready)
  );

  // Remaining stages, one per tree level
  fixed_adder_tree #(
    .IN_SIZE   (IN_SIZE),
    .IN_WIDTH  (PROD_WIDTH),
    .OUT_WIDTH (SUM_WIDTH)
  ) i_fixed_adder_tree (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (prod),
    .data_in_valid  (prod_valid),
    .data_in_ready  (prod_ready),
    .data_out       (sum_out),
    .data_out_valid (out_valid),
    .data_out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: logic/fixed_pkg.sv
`default_nettype none

package fixed_pkg;

  // Default vector length for the top level
  localparam int DEFAULT_IN_SIZE = 8;

  // Default operand width in bits
  localparam int DEFAULT_DATA_WIDTH = 8;

  // Number of adder levels needed to reduce n elements to one
  // ceil(log2(n)), zero for a single element
  function automatic int tree_levels(input int n);
    return (n <= 1) ? 0 : $clog2(n);
  endfunction

  // Element count at level i of the tree
  // ceil(n / 2^i)
  function automatic int level_size(input int n, input int i);
    return (n + ((1 << i) - 1)) >> i;
  endfunction

  // Full product of two unsigned operands needs twice the bits
  function automatic int product_width(input int w);
    return 2 * w;
  endfunction

endpackage

`default_nettype wire

// File: logic/fixed_vector_mult.sv
`timescale 1ns/1ns
`default_nettype none

module fixed_vector_mult #(
  parameter int IN_SIZE    = 8,
  parameter int DATA_WIDTH = 8
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic [DATA_WIDTH-1:0] a_in [IN_SIZE],
  input  wire logic [DATA_WIDTH-1:0] b_in [IN_SIZE],
  input  wire logic                  in_valid,
  output logic                       in_ready,
  output logic [fixed_pkg::product_width(DATA_WIDTH)-1:0] prod_out [IN_SIZE],
  output logic                       prod_valid,
  input  wire logic                  prod_ready
);

  import fixed_pkg::*;

  // Width of one full product
  localparam int PROD_WIDTH = product_width(DATA_WIDTH);

  // Width of all lanes packed together
  localparam int FLAT_WIDTH = IN_SIZE * PROD_WIDTH;

  // Combinational products, one per lane
  logic [PROD_WIDTH-1:0] prod [IN_SIZE];

  // Packed lanes before and after the register slice
  logic [FLAT_WIDTH-1:0] flat_prod;
  logic [FLAT_WIDTH-1:0] flat_out;

  for (genvar k = 0; k < IN_SIZE; k++) begin : g_lane
    // Unsigned multiply at full width, no truncation
    assign prod[k] = PROD_WIDTH'(a_in[k]) * PROD_WIDTH'(b_in[k]);

    // Lane k sits at bit k*PROD_WIDTH
    assign flat_prod[k*PROD_WIDTH +: PROD_WIDTH] = prod[k];
    assign prod_out[k] = flat_out[k*PROD_WIDTH +: PROD_WIDTH];
  end

  // Single slice for all lanes
  // keeps every lane of a vector in the same cycle
  skid_buffer #(
    .DATA_WIDTH (FLAT_WIDTH)
  ) i_skid_buffer (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (flat_prod),
    .data_in_valid  (in_valid),
    .data_in_ready  (in_ready),
    .data_out       (flat_out),
    .data_out_valid (prod_valid),
    .data_out_ready (prod_ready)
  );

endmodule

`default_nettype wire

// File: logic/skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skid_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic [DATA_WIDTH-1:0] data_in,
  input  wire logic                  data_in_valid,
  output logic                       data_in_ready,
  output logic      [DATA_WIDTH-1:0] data_out,
  output logic                       data_out_valid,
  input  wire logic                  data_out_ready
);

  // Main register drives the output side
  logic [DATA_WIDTH-1:0] main_data;
  logic                  main_valid;

  // Skid register holds one extra item while the output stalls
  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;

  // Main register may take a new item this cycle
  logic                  load_main;

  // Output is empty or being drained
  assign load_main = data_out_ready || !main_valid;

  // Accept while the skid slot is free
  // Comes straight from a flop, so no combinational path from data_out_ready
  assign data_in_ready = !skid_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      // Skid entry goes first to keep order
      // Input is blocked in that cycle since ready is low
      main_valid <= skid_valid || data_in_valid;
      skid_valid <= 1'b0;
    end else if (data_in_valid && !skid_valid) begin
      // Output stalled and an item arrived in the cycle ready falls
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      main_data <= skid_valid ? skid_data : data_in;
    end
    // Skid slot follows the input while empty
    // Its content only counts once skid_valid is set
    if (!skid_valid) begin
      skid_data <= data_in;
    end
  end

  assign data_out       = main_data;
  assign data_out_valid = main_valid;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the dot-product testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_fixed_dot_product
LOG=sim.log

rm -rf obj_dir "$LOG"

# Build, then run; all output of the run goes to the log
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module "$TOP" -f flist.f -o "$TOP" \
  && ./obj_dir/"$TOP" > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

# The run passes only if the pass line is in the log
grep -qx "TEST PASSED" "$LOG" 2>/dev/null \
  && echo "Simulation result: pass" && exit 0 \
  || { echo "Simulation result: fail"; exit 1; }

// File: tb/tb_fixed_dot_product.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fixed_dot_product;

  import fixed_pkg::*;

  // DUT sizes follow the package defaults
  localparam int IN_SIZE    = DEFAULT_IN_SIZE;
  localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;

  // One extra bit per adder level on top of the full product
  localparam int LEVELS    = (IN_SIZE > 1) ? $clog2(IN_SIZE) : 0;
  localparam int SUM_WIDTH = 2 * DATA_WIDTH + LEVELS;

  // Multiplier stage plus one stage per tree level
  localparam int LATENCY = 1 + LEVELS;

  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          BURST_LEN      = 16;
  localparam int          RANDOM_VECTORS = 300;
  localparam int unsigned SEED           = 32'h9c0c2af4;

  typedef logic [DATA_WIDTH-1:0] vec_t [IN_SIZE];

  logic                  clk = 1'b0;
  logic                  arst_n;
  logic [DATA_WIDTH-1:0] a_in [IN_SIZE];
  logic [DATA_WIDTH-1:0] b_in [IN_SIZE];
  logic                  in_valid;
  logic                  in_ready;
  logic [SUM_WIDTH-1:0]  sum_out;
  logic                  out_valid;
  logic                  out_ready = 1'b1;

  // Expected sums in input order and the cycle each vector went in
  longint unsigned exp_q [$];
  int unsigned     in_cyc_q [$];

  int unsigned cycle_cnt      = 0;
  int unsigned burst_outputs  = 0;
  int unsigned last_out_cycle = 0;

  // Latency and spacing only hold with out_ready high and an empty pipe
  logic timing_check;

  // Random back-pressure on the output side
  logic random_ready;

  fixed_dot_product #(
    .IN_SIZE    (IN_SIZE),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_fixed_dot_product (
    .clk       (clk),
    .arst_n    (arst_n),
    .a_in      (a_in),
    .b_in      (b_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .sum_out   (sum_out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // Sum of elementwise products in plain integer arithmetic
  function automatic longint unsigned dot_ref(input vec_t a, input vec_t b);
    longint unsigned acc;
    acc = 0;
    for (int k = 0; k < IN_SIZE; k++) begin
      acc += 64'(a[k]) * 64'(b[k]);
    end
    return acc;
  endfunction

  function automatic vec_t fill_vector(input logic [DATA_WIDTH-1:0] value);
    vec_t v;
    for (int k = 0; k < IN_SIZE; k++) begin
      v[k] = value;
    end
    return v;
  endfunction

  function automatic vec_t random_vector();
    vec_t v;
    for (int k = 0; k < IN_SIZE; k++) begin
      v[k] = DATA_WIDTH'($urandom);
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input longint unsigned expected,
                                 input longint unsigned actual);
    $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic abort_run(input string what);
    $display("At %0t ns %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // Cycle count read by the monitors before it moves on
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Input monitor pushes one expected sum per accepted vector
  always @(posedge clk) begin
    if (arst_n && in_valid && in_ready) begin
      exp_q.push_back(dot_ref(a_in, b_in));
      in_cyc_q.push_back(cycle_cnt);
    end
  end

  // Scoreboard on the output side
  always @(posedge clk) begin : compare_outputs
    longint unsigned exp_sum;
    int unsigned     in_cyc;
    if (!timing_check) begin
      burst_outputs <= 0;
    end
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("a result came out with no vector sent for it");
      end else begin
        exp_sum = exp_q.pop_front();
        in_cyc  = in_cyc_q.pop_front();
        assert (64'(sum_out) == exp_sum)
          else report_mismatch("sum_out", exp_sum, 64'(sum_out));
        if (timing_check) begin
          assert (cycle_cnt - in_cyc == LATENCY)
            else report_mismatch("out_valid delay in cycles", 64'(LATENCY),
                                 64'(cycle_cnt - in_cyc));
          // Back to back after the first result of the burst
          if (burst_outputs > 0) begin
            assert (cycle_cnt == last_out_cycle + 1)
              else report_mismatch("out_valid spacing in cycles", 64'(1),
                                   64'(cycle_cnt - last_out_cycle));
          end
          last_out_cycle <= cycle_cnt;
          burst_outputs  <= burst_outputs + 1;
        end
      end
    end
  end

  // out_ready changes 2 ns after the edge like every other input
  always @(posedge clk) begin
    #2;
    if (random_ready) begin
      out_ready = ($urandom % 2) == 0;
    end else begin
      out_ready = 1'b1;
    end
  end

  // Leaves in_valid high so the next call can follow without a gap
  task automatic send_vector(input vec_t a, input vec_t b);
    int unsigned waited;
    waited   = 0;
    a_in     = a;
    b_in     = b;
    in_valid = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("in_ready never came back while a vector was waiting");
      end
      @(posedge clk);
    end
    #2;
  endtask

  task automatic idle_cycles(input int unsigned n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_for_results();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= TIMEOUT_CYCLES) begin
        abort_run("a result never came out on sum_out");
      end
      waited++;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_reset();
    int unsigned waited;
    waited = 0;
    repeat (4) begin
      @(posedge clk);
      #2;
      assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, 64'(out_valid));
    end
    arst_n = 1'b1;
    @(posedge clk);
    #2;
    assert (out_valid == 1'b0) else report_mismatch("out_valid", 0, 64'(out_valid));
    while (!in_ready) begin
      if (waited >= TIMEOUT_CYCLES) begin
        abort_run("in_ready never went high after reset");
      end
      waited++;
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int unsigned gap;
    vec_t        a;
    vec_t        b;
    void'($urandom(SEED));
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    a_in         = fill_vector('0);
    b_in         = fill_vector('0);
    timing_check = 1'b0;
    random_ready = 1'b0;

    check_reset();

    // Directed single vectors
    send_vector(fill_vector('0), fill_vector('0));
    idle_cycles(1);
    send_vector(fill_vector(DATA_WIDTH'(1)), fill_vector(DATA_WIDTH'(1)));
    idle_cycles(1);
    a = fill_vector('0);
    b = fill_vector('0);
    a[IN_SIZE/2] = DATA_WIDTH'(37);
    b[IN_SIZE/2] = DATA_WIDTH'(201);
    send_vector(a, b);
    idle_cycles(1);
    wait_for_results();

    // Largest operands reach the top bit of sum_out
    send_vector(fill_vector('1), fill_vector('1));
    idle_cycles(1);
    wait_for_results();

    // Back-to-back burst with out_ready held high
    timing_check = 1'b1;
    for (int n = 0; n < BURST_LEN; n++) begin
      send_vector(random_vector(), random_vector());
    end
    idle_cycles(1);
    wait_for_results();
    timing_check = 1'b0;

    // Random input gaps against random output stalls
    random_ready = 1'b1;
    for (int n = 0; n < RANDOM_VECTORS; n++) begin
      a = random_vector();
      b = random_vector();
      send_vector(a, b);
      gap = $urandom % 3;
      if (gap != 0) begin
        idle_cycles(gap);
      end
    end
    idle_cycles(1);
    wait_for_results();
    random_ready = 1'b0;
    idle_cycles(2);

    if (exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("%0d results never came out", exp_q.size());
      $display("TEST FAILED");
      $fatal(1, "results missing");
    end
  end

endmodule

`default_nettype wire
